//--- source/tm1638_pkg.sv
package tm1638_pkg;

	// one queued byte plus its framing flags
	typedef struct packed {
		logic [7:0] data;  // byte on the wire
		logic       last;  // strobe rises after this byte
		logic       rd;    // four key bytes follow this command
	} tm_byte_t;

	typedef logic [7:0] tm_keys_t;  // bit i set = button i pressed

	// TM1638 commands
	localparam logic [7:0] CMD_AUTO_INC   = 8'h40;  // write, auto increment
	localparam logic [7:0] CMD_READ_KEYS  = 8'h42;  // key scan read
	localparam logic [7:0] CMD_ADDR0      = 8'hc0;  // address 0
	localparam logic [7:0] CMD_DISPLAY_ON = 8'h88;  // OR in brightness

	// digit 0 holds the first letter, in the top byte
	localparam logic [63:0] BANNER = "kill bit";

	// segment pattern, bit 0 = segment a, bit 7 = dp
	function automatic logic [7:0] seg_char(input logic [7:0] c);
		case (c)
			"k":     return 8'b0111_0101;
			"i":     return 8'b0001_0001;
			"l":     return 8'b0011_1000;
			"b":     return 8'b0111_1100;
			"t":     return 8'b0111_1000;
			" ":     return 8'b0000_0000;  // blank
			default: return 8'b1000_0000;  // dp marks unknown
		endcase
	endfunction

	// letter of BANNER shown on digit d
	function automatic logic [7:0] banner_char(input logic [2:0] d);
		logic [5:0] lsb;
		lsb = {3'd7 - d, 3'b000};
		return BANNER[lsb +: 8];
	endfunction

endpackage

//--- source/ledkey_app.sv
`timescale 1ns/100ps

module ledkey_app #(
	parameter int         QUEUE_DEPTH = 4,
	parameter logic [2:0] BRIGHTNESS  = 3'd7
) (
	input  logic                 i_clk,
	input  logic                 rst_n,
	output logic                 o_wr_valid,
	output tm1638_pkg::tm_byte_t o_wr_byte,
	input  logic                 i_credit,
	input  tm1638_pkg::tm_keys_t i_keys,
	input  logic                 i_keys_valid,
	input  logic                 i_idle
);

	localparam int CW = $clog2(QUEUE_DEPTH + 1);

	typedef enum logic [2:0] {
		ST_INIT_MODE,   // auto increment command
		ST_INIT_CLEAR,  // address 0 and 16 zero bytes
		ST_INIT_ON,     // display on
		ST_READ,        // key read command
		ST_WAIT_KEYS,
		ST_UPDATE,      // 17-byte display frame
		ST_WAIT_IDLE
	} state_t;

	state_t               state;
	state_t               after_frame;
	logic [4:0]           idx;          // byte index inside a frame
	logic [CW-1:0]        credits;
	tm1638_pkg::tm_keys_t keys;
	tm1638_pkg::tm_byte_t next_byte;
	logic [2:0]           digit;
	logic                 sending;
	logic                 spend;

	// odd idx carries segments, even idx the LED of the same digit
	assign digit   = idx[0] ? idx[3:1] : idx[3:1] - 3'd1;
	assign sending = (state != ST_WAIT_KEYS) && (state != ST_WAIT_IDLE);
	assign spend   = sending && (credits != '0);

	always_comb begin
		next_byte   = '0;
		after_frame = state;
		case (state)
			ST_INIT_MODE: begin
				next_byte.data = tm1638_pkg::CMD_AUTO_INC;
				next_byte.last = 1'b1;
				after_frame    = ST_INIT_CLEAR;
			end
			ST_INIT_CLEAR: begin
				next_byte.data = (idx == '0) ? tm1638_pkg::CMD_ADDR0 : 8'h00;
				next_byte.last = (idx == 5'd16);
				after_frame    = ST_INIT_ON;
			end
			ST_INIT_ON: begin
				next_byte.data = tm1638_pkg::CMD_DISPLAY_ON | {5'b0, BRIGHTNESS};
				next_byte.last = 1'b1;
				after_frame    = ST_READ;
			end
			ST_READ: begin
				next_byte.data = tm1638_pkg::CMD_READ_KEYS;
				next_byte.last = 1'b1;
				next_byte.rd   = 1'b1;
				after_frame    = ST_WAIT_KEYS;
			end
			ST_UPDATE: begin
				if (idx == '0)
					next_byte.data = tm1638_pkg::CMD_ADDR0;
				else if (idx[0])
					next_byte.data = keys[digit] ? tm1638_pkg::seg_char(" ")
						: tm1638_pkg::seg_char(tm1638_pkg::banner_char(digit));
				else
					next_byte.data = {7'b0, keys[digit]};  // LED on while pressed
				next_byte.last = (idx == 5'd16);
				after_frame    = ST_WAIT_IDLE;
			end
			default: ;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (!rst_n) begin
			state      <= ST_INIT_MODE;
			idx        <= '0;
			credits    <= CW'(QUEUE_DEPTH);
			o_wr_valid <= 1'b0;
			keys       <= '0;
		end else begin
			o_wr_valid <= spend;
			credits    <= credits - CW'(spend) + CW'(i_credit);  // both may happen at once
			case (state)
				ST_WAIT_KEYS: if (i_keys_valid) begin
					keys  <= i_keys;
					state <= ST_UPDATE;
				end
				// nothing left in flight and the wire is quiet
				ST_WAIT_IDLE: if (i_idle && credits == CW'(QUEUE_DEPTH))
					state <= ST_READ;
				default: if (spend) begin
					idx <= next_byte.last ? 5'd0 : idx + 5'd1;
					if (next_byte.last)
						state <= after_frame;
				end
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (spend)
			o_wr_byte <= next_byte;
	end

	// queue must hand back no more credits than it has slots
	a_credit_bound: assert property (@(posedge i_clk) disable iff (!rst_n)
		credits <= CW'(QUEUE_DEPTH))
		else $error("credit count above queue depth");

endmodule

//--- source/tm1638_frame_queue.sv
`timescale 1ns/100ps

module tm1638_frame_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                 i_clk,
	input  logic                 rst_n,
	input  logic                 i_wr_valid,
	input  tm1638_pkg::tm_byte_t i_wr_byte,
	output logic                 o_credit,
	output logic                 o_rd_valid,
	output tm1638_pkg::tm_byte_t o_rd_byte,
	input  logic                 i_pop
);

	localparam int AW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CW = $clog2(QUEUE_DEPTH + 1);

	tm1638_pkg::tm_byte_t mem [QUEUE_DEPTH];
	logic [AW-1:0]        wr_ptr;
	logic [AW-1:0]        rd_ptr;
	logic [CW-1:0]        count;
	logic                 pull;

	assign o_rd_valid = (count != '0);
	assign o_rd_byte  = mem[rd_ptr];  // head shown as long as it is valid
	assign pull       = i_pop && o_rd_valid;

	always_ff @(posedge i_clk) begin
		if (i_wr_valid)
			mem[wr_ptr] <= i_wr_byte;
	end

	always_ff @(posedge i_clk) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			o_credit <= 1'b0;
		end else begin
			o_credit <= pull;  // one credit back per popped byte
			if (i_wr_valid)
				wr_ptr <= (wr_ptr == AW'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pull)
				rd_ptr <= (rd_ptr == AW'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CW'(i_wr_valid) - CW'(pull);
		end
	end

	a_no_overflow: assert property (@(posedge i_clk) disable iff (!rst_n)
		i_wr_valid |-> count < CW'(QUEUE_DEPTH))
		else $error("write into full frame queue");

	a_no_underflow: assert property (@(posedge i_clk) disable iff (!rst_n)
		i_pop |-> o_rd_valid)
		else $error("pop from empty frame queue");

endmodule

//--- source/tm1638_serializer.sv
`timescale 1ns/100ps

module tm1638_serializer #(
	parameter int CLK_DIV = 4
) (
	input  logic                 i_clk,
	input  logic                 rst_n,
	input  logic                 i_rd_valid,
	input  tm1638_pkg::tm_byte_t i_rd_byte,
	output logic                 o_pop,
	output tm1638_pkg::tm_keys_t o_keys,
	output logic                 o_keys_valid,
	output logic                 o_idle,
	output logic                 o_tm_clk,
	output logic                 o_tm_stb,
	output logic                 o_tm_dout,
	output logic                 o_tm_doe,
	input  logic                 i_tm_din
);

	localparam int DW = $clog2(CLK_DIV);

	typedef enum logic [2:0] {S_IDLE, S_LEAD, S_XFER, S_WAIT, S_STOP, S_GAP} state_t;

	state_t        state;
	logic [DW-1:0] div_cnt;
	logic          tick;      // half period boundary
	logic [3:0]    hcnt;      // half period inside a byte
	logic [7:0]    shreg;
	logic          cur_last;
	logic          cur_rd;
	logic          reading;   // data released, key bytes coming in
	logic [1:0]    rd_cnt;

	assign tick   = (div_cnt == '0);
	assign o_idle = (state == S_IDLE) && !i_rd_valid;

	always_ff @(posedge i_clk) begin
		if (!rst_n || tick)
			div_cnt <= DW'(CLK_DIV - 1);
		else
			div_cnt <= div_cnt - 1'b1;
	end

	always_ff @(posedge i_clk) begin
		if (!rst_n) begin
			state        <= S_IDLE;
			o_tm_stb     <= 1'b1;
			o_tm_clk     <= 1'b1;  // clock idles high
			o_tm_dout    <= 1'b1;
			o_tm_doe     <= 1'b0;
			o_pop        <= 1'b0;
			o_keys       <= '0;
			o_keys_valid <= 1'b0;
			hcnt         <= '0;
			shreg        <= '0;
			cur_last     <= 1'b0;
			cur_rd       <= 1'b0;
			reading      <= 1'b0;
			rd_cnt       <= '0;
		end else begin
			o_pop        <= 1'b0;
			o_keys_valid <= 1'b0;
			case (state)
				S_IDLE, S_WAIT: if (i_rd_valid) begin
					o_pop    <= 1'b1;
					o_tm_stb <= 1'b0;  // already low in S_WAIT
					o_tm_doe <= 1'b1;
					shreg    <= i_rd_byte.data;
					cur_last <= i_rd_byte.last;
					cur_rd   <= i_rd_byte.rd;
					state    <= S_LEAD;
				end
				S_LEAD: if (tick) begin
					o_tm_clk  <= 1'b0;
					o_tm_dout <= shreg[0];
					hcnt      <= '0;
					state     <= S_XFER;
				end
				S_XFER: if (tick) begin
					hcnt <= hcnt + 4'd1;  // wraps to 0 for the next byte
					if (!hcnt[0]) begin
						o_tm_clk <= 1'b1;  // rising edge, board samples
						shreg    <= {i_tm_din, shreg[7:1]};
					end else if (hcnt != 4'd15) begin
						o_tm_clk  <= 1'b0;
						o_tm_dout <= shreg[0];  // change on falling edge
					end else if (reading) begin
						o_keys[{1'b0, rd_cnt}] <= shreg[0];
						o_keys[{1'b1, rd_cnt}] <= shreg[4];
						rd_cnt <= rd_cnt + 2'd1;
						if (rd_cnt == 2'd3)
							state <= S_STOP;
						else
							o_tm_clk <= 1'b0;
					end else if (cur_rd) begin
						reading  <= 1'b1;  // turn the data line around
						o_tm_doe <= 1'b0;
						rd_cnt   <= '0;
						o_tm_clk <= 1'b0;
					end else if (cur_last) begin
						state <= S_STOP;
					end else if (i_rd_valid) begin
						// next byte back to back
						o_pop     <= 1'b1;
						o_tm_clk  <= 1'b0;
						o_tm_dout <= i_rd_byte.data[0];
						shreg     <= i_rd_byte.data;
						cur_last  <= i_rd_byte.last;
						cur_rd    <= i_rd_byte.rd;
					end else begin
						state <= S_WAIT;  // hold strobe low, clock high
					end
				end
				S_STOP: if (tick) begin
					o_tm_stb     <= 1'b1;
					o_tm_doe     <= 1'b0;
					o_tm_dout    <= 1'b1;
					o_keys_valid <= reading;
					reading      <= 1'b0;
					state        <= S_GAP;
				end
				S_GAP: if (tick)
					state <= S_IDLE;  // minimum strobe high time
				default: state <= S_IDLE;
			endcase
		end
	end

	// frame end with clock low would corrupt the last bit on the board
	a_stb_clk_high: assert property (@(posedge i_clk) disable iff (!rst_n)
		$rose(o_tm_stb) |-> o_tm_clk)
		else $error("strobe rose while serial clock low");

endmodule

//--- source/ledkey_top.sv
`timescale 1ns/100ps

module ledkey_top #(
	parameter int         CLK_DIV     = 4,
	parameter int         QUEUE_DEPTH = 4,
	parameter logic [2:0] BRIGHTNESS  = 3'd7
) (
	input  logic       i_clk,
	input  logic       rst_n,
	output logic       o_ledkey_clk,
	output logic       o_ledkey_stb,
	inout  wire        io_ledkey_dio,
	output logic [7:0] o_led
);

	tm1638_pkg::tm_byte_t wr_byte;
	tm1638_pkg::tm_byte_t rd_byte;
	tm1638_pkg::tm_keys_t keys;
	logic                 wr_valid;
	logic                 credit;
	logic                 rd_valid;
	logic                 pop;
	logic                 keys_valid;
	logic                 idle;
	logic                 tm_dout;
	logic                 tm_doe;

	assign io_ledkey_dio = tm_doe ? tm_dout : 1'bz;  // board pulls data up
	assign o_led         = idle ? ~keys : '1;          // all off while busy

	ledkey_app #(
		.QUEUE_DEPTH (QUEUE_DEPTH),
		.BRIGHTNESS  (BRIGHTNESS)
	) u_app (
		.i_clk        (i_clk),
		.rst_n        (rst_n),
		.o_wr_valid   (wr_valid),
		.o_wr_byte    (wr_byte),
		.i_credit     (credit),
		.i_keys       (keys),
		.i_keys_valid (keys_valid),
		.i_idle       (idle)
	);

	tm1638_frame_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) u_queue (
		.i_clk      (i_clk),
		.rst_n      (rst_n),
		.i_wr_valid (wr_valid),
		.i_wr_byte  (wr_byte),
		.o_credit   (credit),
		.o_rd_valid (rd_valid),
		.o_rd_byte  (rd_byte),
		.i_pop      (pop)
	);

	tm1638_serializer #(
		.CLK_DIV (CLK_DIV)
	) u_serializer (
		.i_clk        (i_clk),
		.rst_n        (rst_n),
		.i_rd_valid   (rd_valid),
		.i_rd_byte    (rd_byte),
		.o_pop        (pop),
		.o_keys       (keys),
		.o_keys_valid (keys_valid),
		.o_idle       (idle),
		.o_tm_clk     (o_ledkey_clk),
		.o_tm_stb     (o_ledkey_stb),
		.o_tm_dout    (tm_dout),
		.o_tm_doe     (tm_doe),
		.i_tm_din     (io_ledkey_dio)
	);

endmodule

//--- verif/tm1638_board_model.sv
`timescale 1ns/100ps

module tm1638_board_model (
	input  logic            i_tm_clk,
	input  logic            i_tm_stb,
	inout  wire             io_tm_dio,
	input  logic [7:0]      i_keys,      // 1 = button pressed
	output logic [8*17-1:0] o_frame,     // byte 0 in the low bits
	output int              o_len,
	output int              o_key_bits,
	output int              o_bits_left,
	output logic            o_edges_ok,  // clock was high at every strobe edge
	output int              o_frames
);

	logic            drive_en;
	logic            drive_val;
	logic            active;   // strobe low, frame in progress
	logic            reading;  // key bytes go back to the controller
	logic [7:0]      shift;
	logic [8*17-1:0] bytes;
	int              nbit;
	int              nbyte;
	int              rbit;

	pullup (io_tm_dio);
	assign io_tm_dio = drive_en ? drive_val : 1'bz;

	// key byte k: bit 0 = button k, bit 4 = button k+4
	function automatic logic key_bit(input int n);
		int k;
		int b;
		k = n / 8;
		b = n % 8;
		if (b == 0)
			return i_keys[k];
		else if (b == 4)
			return i_keys[k+4];
		return 1'b0;
	endfunction

	initial begin
		drive_en   = 1'b0;
		drive_val  = 1'b1;
		active     = 1'b0;
		reading    = 1'b0;
		o_frame    = '0;
		o_len      = 0;
		o_key_bits = 0;
		o_edges_ok = 1'b1;
		o_frames   = 0;
	end

	always @(negedge i_tm_stb) begin
		if (i_tm_clk !== 1'b1)
			o_edges_ok = 1'b0;
		active  = 1'b1;
		reading = 1'b0;
		nbit    = 0;
		nbyte   = 0;
		rbit    = 0;
		bytes   = '0;
	end

	always @(posedge i_tm_stb) begin
		if (active) begin  // ignore the rise out of reset
			if (i_tm_clk !== 1'b1)
				o_edges_ok = 1'b0;
			drive_en    = 1'b0;
			active      = 1'b0;
			o_frame     = bytes;
			o_len       = nbyte;
			o_key_bits  = rbit;
			o_bits_left = nbit;
			o_frames    = o_frames + 1;  // updated last, frame data already set
		end
	end

	always @(posedge i_tm_clk) begin
		if (active && reading) begin
			rbit = rbit + 1;
		end else if (active) begin
			shift = {io_tm_dio, shift[7:1]};  // lsb first
			nbit  = nbit + 1;
			if (nbit == 8) begin
				if (nbyte < 17)
					bytes[8*nbyte +: 8] = shift;
				if (nbyte == 0 && shift == 8'h42)
					reading = 1'b1;
				nbyte = nbyte + 1;
				nbit  = 0;
			end
		end
	end

	// board changes data after the falling edge
	always @(negedge i_tm_clk) begin
		if (active && reading && rbit < 32) begin
			#1;
			drive_val = key_bit(rbit);
			drive_en  = 1'b1;
		end
	end

endmodule

//--- verif/ledkey_tb.sv
`timescale 1ns/100ps

module ledkey_tb;

	localparam int         CLK_DIV     = 4;
	localparam int         QUEUE_DEPTH = 4;
	localparam logic [2:0] BRIGHTNESS  = 3'd7;
	localparam int         ROUNDS      = 22;  // released, all pressed, 20 random
	localparam int         FRAME_LEN   = 17;
	localparam int         TIMEOUT_NS  = (ROUNDS + 1) * 20 * 16 * CLK_DIV * 20 * 4;

	logic                   i_clk;
	logic                   rst_n;
	logic                   ledkey_clk;
	logic                   ledkey_stb;
	wire                    ledkey_dio;
	logic [7:0]             led;
	logic [7:0]             key_pat;     // buttons the board reports
	logic [7:0]             shown_keys;  // buttons of the last finished read
	logic [8*FRAME_LEN-1:0] frame;
	logic                   edges_ok;
	logic                   led_armed;
	logic [31:0]            rng;
	int                     frame_len;
	int                     key_bits;
	int                     bits_left;
	int                     frames;
	int                     seen;
	int                     led_samples;

	ledkey_top #(
		.CLK_DIV     (CLK_DIV),
		.QUEUE_DEPTH (QUEUE_DEPTH),
		.BRIGHTNESS  (BRIGHTNESS)
	) UUT (
		.i_clk         (i_clk),
		.rst_n         (rst_n),
		.o_ledkey_clk  (ledkey_clk),
		.o_ledkey_stb  (ledkey_stb),
		.io_ledkey_dio (ledkey_dio),
		.o_led         (led)
	);

	tm1638_board_model u_board (
		.i_tm_clk    (ledkey_clk),
		.i_tm_stb    (ledkey_stb),
		.io_tm_dio   (ledkey_dio),
		.i_keys      (key_pat),
		.o_frame     (frame),
		.o_len       (frame_len),
		.o_key_bits  (key_bits),
		.o_bits_left (bits_left),
		.o_edges_ok  (edges_ok),
		.o_frames    (frames)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// address command, then segment and LED byte per digit
	function automatic logic [8*FRAME_LEN-1:0] expected_display(input logic [7:0] keys);
		logic [8*FRAME_LEN-1:0] f;
		logic [7:0]             letter;
		int                     i;
		f       = '0;
		f[7:0]  = 8'hc0;
		for (i = 0; i < 8; i++) begin
			letter              = tm1638_pkg::BANNER[8*(7-i) +: 8];  // first letter on top
			f[8*(2*i+1) +: 8]   = keys[i] ? 8'h00 : tm1638_pkg::seg_char(letter);
			f[8*(2*i+2) +: 8]   = {7'b0, keys[i]};
		end
		return f;
	endfunction

	task automatic expect_equal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0d ns: %s = %h, expected %h", $time, name, got, exp);
			$display("Test failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic await_frame();
		wait (frames > seen);
		seen = seen + 1;
		expect_equal("clock at strobe edge", edges_ok, 1);
		expect_equal("bits after last byte", bits_left, 0);
	endtask

	always #10 i_clk = ~i_clk;

	initial begin
		i_clk   = 1'b0;
		rst_n   = 1'b0;
		key_pat = '0;
		rng     = 32'h36ad;
		repeat (8) @(posedge i_clk);
		#2 rst_n = 1'b1;
		for (int r = 0; r < ROUNDS; r++) begin
			wait (frames == 3 + 2 * r);  // init done or last update frame out
			@(posedge i_clk);
			#2;
			if (r == 0) begin
				key_pat = 8'h00;
			end else if (r == 1) begin
				key_pat = 8'hff;
			end else begin
				rng     = xorshift32(rng);
				key_pat = rng[7:0];
			end
		end
	end

	// led shows the keys only while the wire is quiet
	always @(negedge i_clk) begin
		if (led_armed && ledkey_stb === 1'b1 && UUT.idle === 1'b1) begin
			expect_equal("o_led", led, 8'(~shown_keys));
			led_samples = led_samples + 1;
		end else if (led_armed && ledkey_stb === 1'b0) begin
			expect_equal("o_led", led, 8'hff);  // all off while a frame is on the wire
		end
	end

	initial begin : compare
		logic [8*FRAME_LEN-1:0] exp_frame;
		logic [7:0]             pat;
		int                     i;
		seen        = 0;
		shown_keys  = '0;
		led_samples = 0;
		led_armed   = 1'b0;
		wait (rst_n === 1'b1);
		led_armed = 1'b1;
		await_frame();
		expect_equal("mode frame length", frame_len, 1);
		expect_equal("mode command", frame[7:0], 8'h40);
		await_frame();
		expect_equal("clear frame length", frame_len, FRAME_LEN);
		expect_equal("clear address", frame[7:0], 8'hc0);
		for (i = 1; i < FRAME_LEN; i++)
			expect_equal($sformatf("clear byte %0d", i), frame[8*i +: 8], 8'h00);
		await_frame();
		expect_equal("control frame length", frame_len, 1);
		expect_equal("display control", frame[7:0], 8'h88 | {5'b0, BRIGHTNESS});
		for (int r = 0; r < ROUNDS; r++) begin
			await_frame();
			pat = key_pat;
			expect_equal("read frame length", frame_len, 1);
			expect_equal("read command", frame[7:0], 8'h42);
			expect_equal("key bits clocked", key_bits, 32);
			shown_keys = pat;
			await_frame();
			exp_frame = expected_display(pat);
			expect_equal("display frame length", frame_len, FRAME_LEN);
			expect_equal("key bits in write frame", key_bits, 0);
			for (i = 0; i < FRAME_LEN; i++)
				expect_equal($sformatf("display byte %0d", i), frame[8*i +: 8],
					exp_frame[8*i +: 8]);
			if (pat == 8'h00) begin
				for (i = 1; i < FRAME_LEN; i += 2)
					expect_equal("unknown letter", frame[8*i +: 8] == 8'h80, 0);
			end
		end
		expect_equal("idle led samples seen", led_samples > 0, 1);
		$display("Test passed");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the display frames stopped arriving");
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- verilog.f
source/tm1638_pkg.sv
source/ledkey_app.sv
source/tm1638_frame_queue.sv
source/tm1638_serializer.sv
source/ledkey_top.sv
verif/tm1638_board_model.sv
verif/ledkey_tb.sv

//--- Bender.yml
package:
  name: ledkey_tm1638

sources:
  - files:
      - source/tm1638_pkg.sv
      - source/ledkey_app.sv
      - source/tm1638_frame_queue.sv
      - source/tm1638_serializer.sv
      - source/ledkey_top.sv
  - target: test
    files:
      - verif/tm1638_board_model.sv
      - verif/ledkey_tb.sv
